// File: files.f
+incdir+verilog
verilog/fm_pkg.sv
verilog/fm_op_params_if.sv
verilog/fm_op_data_phase.sv
verilog/fm_op_regs.sv
verilog/fm_vib_timer.sv
verilog/fm_op_seq.sv
verilog/fm_phase.sv
verilog/fm_phase_top.sv
tests/fm_clk_gen.sv
tests/fm_phase_asserts.sv
tests/fm_phase_tb.sv

// File: Bender.yml
package:
  name: fm_phase

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fm_pkg.sv
      - verilog/fm_op_params_if.sv
      - verilog/fm_op_data_phase.sv
      - verilog/fm_op_regs.sv
      - verilog/fm_vib_timer.sv
      - verilog/fm_op_seq.sv
      - verilog/fm_phase.sv
      - verilog/fm_phase_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/fm_clk_gen.sv
      - tests/fm_phase_asserts.sv
      - tests/fm_phase_tb.sv

// File: tests/fm_phase_tb.sv
`timescale 1ns/100ps
`include "fm_config.svh"

module fm_phase_tb;

    localparam int VIB_DIV = 4;
    localparam int NUM_OPS = `FM_NUM_OPS;

    logic clk, rst_n, run;
    logic reg_valid, reg_ready, reg_dvb, reg_vib, reg_key_on;
    fm_pkg::op_idx_t reg_op, out_op;
    fm_pkg::block_t reg_block;
    fm_pkg::fnum_t reg_fnum;
    fm_pkg::mult_t reg_mult;
    logic out_valid, out_ready;
    fm_pkg::phase_t out_phase;

    logic [31:0] lfsr = 32'h0add23d1;
    logic [31:0] ready_lfsr = 32'h0add23d1;
    string test_name = "reset";
    int mult_tab [16] = '{1, 2, 4, 6, 8, 10, 12, 14, 16, 18, 20, 20, 24, 24, 30, 30};

    // model state with cfg packed as {dvb, vib, mult, block, fnum}.
    logic [18:0] cfg [NUM_OPS];
    fm_pkg::acc_t acc [NUM_OPS];
    logic [NUM_OPS-1:0] pending = '0;
    int slot = 0;
    int sweeps = 0;
    logic [15:0] expect_q [$];   // {op, phase} per slot advance.
    logic prev_valid = 1'b0;
    logic prev_ready = 1'b0;

    fm_clk_gen i_fm_clk_gen (.clk(clk), .rst_n(rst_n));

    fm_phase_top #(.VIB_DIV(VIB_DIV)) i_fm_phase_top (.*);

    ////////////////////////////////////////////////////////////
    // random source and reference
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [18:0] rand_cfg(logic dvb, logic vib);
        fm_pkg::fnum_t fnum;
        fm_pkg::block_t block;
        fm_pkg::mult_t mult;
        fnum = fm_pkg::fnum_t'(rand_bits(10));
        block = fm_pkg::block_t'(rand_bits(3));
        mult = fm_pkg::mult_t'(rand_bits(4));
        if (vib && fnum > 10'd1016) fnum = fnum - 10'd16;   // fnum plus range stays in 10 bits.
        return {dvb, vib, mult, block, fnum};
    endfunction

    function automatic fm_pkg::acc_t calc_phase_inc(logic [18:0] c, fm_pkg::vib_pos_t vp);
        int fnum;
        int range;
        int f;
        fnum = c[9:0];
        range = c[9:7];
        if (!c[17] || vp[1:0] == 2'd0) range = 0;
        else if (vp[0]) range = range / 2;
        if (!c[18]) range = range / 2;
        f = vp[2] ? fnum - range : fnum + range;
        return fm_pkg::acc_t'((((f << c[12:10]) / 2) * mult_tab[c[16:13]]) / 2);
    endfunction

    task automatic stop_on_error(string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            stop_on_error($sformatf("ERR %s %s: expected %0h actual %0h",
                                    test_name, what, expected, actual));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////

    // a negative target aims at the slot the sequencer is about to advance.
    task automatic write_op(int target, logic [18:0] c, logic key_on);
        fm_pkg::op_idx_t op;
        int t;
        @(posedge clk);
        #1;
        op = (target < 0) ? fm_pkg::op_idx_t'((slot + 1) % NUM_OPS)
                          : fm_pkg::op_idx_t'(target);
        reg_op = op;
        {reg_dvb, reg_vib, reg_mult, reg_block, reg_fnum} = c;
        reg_key_on = key_on;
        reg_valid = 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (!run) begin
                check_value("reg_ready", 1, reg_ready);   // nothing advances while stopped.
            end
            if (t > 100) stop_on_error("timeout: register write was never accepted");
        end while (!reg_ready);
        @(posedge clk);
        #1;
        cfg[op] = c;
        if (key_on) pending[op] = 1'b1;
        reg_valid = 1'b0;
    endtask

    task automatic set_run(logic v);
        @(posedge clk);
        #1;
        run = v;
    endtask

    task automatic run_sweeps(int n);
        int target;
        int t;
        target = sweeps + n;
        t = 0;
        while (sweeps < target) begin
            @(posedge clk);
            t++;
            if (t > n * NUM_OPS * 8 + 100) stop_on_error("timeout: sequencer stopped sweeping");
        end
    endtask

    task automatic drain_output();
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > 200) stop_on_error("timeout: output stream did not drain");
        end while (prev_valid || expect_q.size() != 0);
    endtask

    task automatic wait_reset_done();
        int t;
        t = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            t++;
            if (t > 50) stop_on_error("timeout: reset was never released");
        end
    endtask

    initial begin : drive_ready
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            ready_lfsr = lfsr_step(ready_lfsr);
            out_ready = ready_lfsr[0];
            ready_lfsr = lfsr_step(ready_lfsr);
            out_ready = out_ready | ready_lfsr[0];   // ready three cycles out of four.
        end
    end

    // every new result pushes the model's expectation and every accepted one is compared.
    always @(negedge clk) begin : compare
        fm_pkg::acc_t inc;
        logic [15:0] item;
        if (i_fm_phase_top.i_fm_phase_asserts.fail_count != 0) begin
            stop_on_error("an assertion on the DUT handshakes failed");
        end
        if (rst_n) begin
            if (out_valid && (!prev_valid || prev_ready)) begin
                inc = calc_phase_inc(cfg[slot], fm_pkg::vib_pos_t'((sweeps / VIB_DIV) % 8));
                acc[slot] = (pending[slot] ? '0 : acc[slot]) + inc;
                pending[slot] = 1'b0;
                expect_q.push_back({6'(slot), acc[slot][18 -: 10]});
                if (slot == NUM_OPS - 1) sweeps++;
                slot = (slot + 1) % NUM_OPS;
            end
            if (out_valid && out_ready) begin
                if (expect_q.size() == 0) stop_on_error("output accepted with no slot advance");
                item = expect_q.pop_front();
                check_value("out_op", item[15:10], out_op);
                check_value("out_phase", item[9:0], out_phase);
            end
        end
        prev_valid = rst_n && out_valid;
        prev_ready = out_ready;
    end

    initial begin : stimulus
        logic [18:0] c;
        logic dvb, vib, key_on;
        int tgt;
        run = 1'b0;
        reg_valid = 1'b0;
        reg_op = '0;
        {reg_dvb, reg_vib, reg_mult, reg_block, reg_fnum} = '0;
        reg_key_on = 1'b0;
        wait_reset_done();

        test_name = "mult_block";
        for (int r = 0; r < 8; r++) begin
            for (int i = 0; i < NUM_OPS; i++) begin
                c = rand_cfg(1'b0, 1'b0);
                c[16:10] = {4'(i % 16), 3'((i + r) % 8)};
                write_op(i, c, 1'b1);   // key-on starts each accumulator.
            end
            set_run(1'b1);
            run_sweeps(3);
            set_run(1'b0);
            drain_output();
        end

        test_name = "restart";
        set_run(1'b1);
        for (int i = 0; i < NUM_OPS; i += 5) begin
            write_op(i, cfg[i], 1'b1);
        end
        run_sweeps(2);

        test_name = "vibrato";
        for (int i = 0; i < NUM_OPS; i++) begin
            write_op(i, rand_cfg(i[0], 1'b1), 1'b1);
        end
        run_sweeps(34);

        test_name = "live_writes";
        for (int i = 0; i < 60; i++) begin
            dvb = 1'(rand_bits(1));
            vib = 1'(rand_bits(1));
            key_on = 1'(rand_bits(1));
            tgt = (i % 2 == 1) ? -1 : int'(rand_bits(6)) % NUM_OPS;
            write_op(tgt, rand_cfg(dvb, vib), key_on);
        end
        run_sweeps(2);
        set_run(1'b0);
        drain_output();

        if (i_fm_phase_top.i_fm_phase_asserts.fail_count != 0) begin
            stop_on_error("an assertion on the DUT handshakes failed");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: tests/fm_phase_asserts.sv
`timescale 1ns/100ps
`include "fm_config.svh"

module fm_phase_asserts (
    input logic            clk,
    input logic            rst_n,
    input logic            reg_ready,
    input logic            out_valid,
    input logic            out_ready,
    input fm_pkg::op_idx_t out_op,
    input fm_pkg::phase_t  out_phase
);

    int unsigned fail_count = 0;   // failed assertions so far.

    // a stalled result holds until the sink takes it.
    out_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_op) && $stable(out_phase))
        else begin
            fail_count++;
            $error("output stream changed while stalled");
        end

    ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> reg_ready)
        else begin
            fail_count++;
            $error("reg_ready low when reset was released");
        end

    op_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_op < `FM_NUM_OPS)
        else begin
            fail_count++;
            $error("out_op beyond the last operator slot");
        end

endmodule

bind fm_phase_top fm_phase_asserts i_fm_phase_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_ready (reg_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_op    (out_op),
    .out_phase (out_phase)
);

// File: tests/fm_clk_gen.sv
`timescale 1ns/100ps

module fm_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: verilog/fm_phase_top.sv
`timescale 1ns/100ps
`include "fm_config.svh"

module fm_phase_top #(
    parameter int VIB_DIV = `FM_VIB_DIV
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            run,

    // register port
    input  logic            reg_valid,
    output logic            reg_ready,
    input  fm_pkg::op_idx_t reg_op,
    input  fm_pkg::block_t  reg_block,
    input  fm_pkg::fnum_t   reg_fnum,
    input  fm_pkg::mult_t   reg_mult,
    input  logic            reg_dvb,
    input  logic            reg_vib,
    input  logic            reg_key_on,

    // phase stream
    output logic            out_valid,
    input  logic            out_ready,
    output fm_pkg::op_idx_t out_op,
    output fm_pkg::phase_t  out_phase
);

    fm_pkg::op_idx_t  op_sel;
    logic             next;
    logic             sample_tick;
    logic             stall;
    fm_pkg::vib_pos_t vib_pos;

    fm_op_params_if params_if ();

    fm_op_regs i_fm_op_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_valid  (reg_valid),
        .reg_ready  (reg_ready),
        .reg_op     (reg_op),
        .reg_block  (reg_block),
        .reg_fnum   (reg_fnum),
        .reg_mult   (reg_mult),
        .reg_dvb    (reg_dvb),
        .reg_vib    (reg_vib),
        .reg_key_on (reg_key_on),
        .busy_op    (op_sel),
        .busy       (next),
        .params     (params_if.src)
    );

    fm_vib_timer #(
        .VIB_DIV (VIB_DIV)
    ) i_fm_vib_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_tick (sample_tick),
        .vib_pos     (vib_pos)
    );

    fm_op_seq i_fm_op_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .stall       (stall),
        .op_sel      (op_sel),
        .next        (next),
        .sample_tick (sample_tick)
    );

    fm_phase i_fm_phase (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_sel    (op_sel),
        .next      (next),
        .vib_pos   (vib_pos),
        .params    (params_if.dst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_op    (out_op),
        .out_phase (out_phase),
        .stall     (stall)
    );

endmodule

// File: verilog/fm_phase.sv
`timescale 1ns/100ps

module fm_phase (
    input  logic             clk,
    input  logic             rst_n,
    input  fm_pkg::op_idx_t  op_sel,
    input  logic             next,
    input  fm_pkg::vib_pos_t vib_pos,
    fm_op_params_if.dst      params,
    output logic             out_valid,
    input  logic             out_ready,
    output fm_pkg::op_idx_t  out_op,
    output fm_pkg::phase_t   out_phase,
    output logic             stall
);

    logic [2:0]    vib_range;
    fm_pkg::fnum_t fnum_vib;
    logic [4:0]    mult_val;
    logic [16:0]   fnum_blk;
    logic [20:0]   fnum_scaled;
    fm_pkg::acc_t  phase_inc;
    fm_pkg::acc_t  acc_q;
    fm_pkg::acc_t  acc_d;

    assign params.op      = op_sel;
    assign params.consume = next;

    ////////////////////////////////////////////////////////////
    // vibrato
    ////////////////////////////////////////////////////////////

    always_comb begin
        vib_range = params.fnum[9:7];
        if (!params.vib || (vib_pos[1:0] == 2'd0)) begin
            vib_range = '0;
        end else if (vib_pos[0]) begin
            vib_range = vib_range >> 1;
        end
        if (!params.dvb) begin
            vib_range = vib_range >> 1;   // shallow depth.
        end
    end

    assign fnum_vib = vib_pos[2] ? params.fnum - {7'b0, vib_range}
                                 : params.fnum + {7'b0, vib_range};

    ////////////////////////////////////////////////////////////
    // block and multiplier scaling
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (params.mult)
            4'd0:    mult_val = 5'd1;    // half, undone by the shift below.
            4'd11:   mult_val = 5'd20;
            4'd12,
            4'd13:   mult_val = 5'd24;
            4'd14,
            4'd15:   mult_val = 5'd30;
            default: mult_val = {params.mult, 1'b0};
        endcase
    end

    assign fnum_blk    = {7'b0, fnum_vib} << params.block;
    assign fnum_scaled = fnum_blk[16:1] * mult_val;
    assign phase_inc   = fnum_scaled[19:1];

    ////////////////////////////////////////////////////////////
    // accumulation
    ////////////////////////////////////////////////////////////

    fm_op_data_phase i_fm_op_data_phase (
        .clk    (clk),
        .idx    (op_sel),
        .wren   (next),
        .wrdata (acc_d),
        .rddata (acc_q)
    );

    // key-on starts the operator from zero.
    assign acc_d = (params.restart ? '0 : acc_q) + phase_inc;

    // output register
    assign stall = out_valid && !out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_op    <= '0;
            out_phase <= '0;
        end else if (next) begin
            out_valid <= 1'b1;
            out_op    <= op_sel;
            out_phase <= acc_d[$bits(acc_d)-1 -: $bits(out_phase)];
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

endmodule

// File: verilog/fm_op_seq.sv
`timescale 1ns/100ps
`include "fm_config.svh"

module fm_op_seq (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            run,
    input  logic            stall,
    output fm_pkg::op_idx_t op_sel,
    output logic            next,
    output logic            sample_tick
);

    localparam fm_pkg::op_idx_t LAST_OP = fm_pkg::op_idx_t'(`FM_NUM_OPS - 1);

    fm_pkg::seq_state_t state;

    // one slot per clock while running and the output drains.
    assign next        = (state != fm_pkg::SEQ_IDLE) && run && !stall;
    assign sample_tick = next && (op_sel == LAST_OP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= fm_pkg::SEQ_IDLE;
        end else begin
            case (state)
                fm_pkg::SEQ_IDLE: begin
                    if (run) begin
                        state <= fm_pkg::SEQ_RUN;
                    end
                end
                fm_pkg::SEQ_RUN: begin
                    if (!run) begin
                        state <= fm_pkg::SEQ_IDLE;
                    end else if (stall) begin
                        state <= fm_pkg::SEQ_STALL;   // hold the slot.
                    end
                end
                fm_pkg::SEQ_STALL: begin
                    if (!run) begin
                        state <= fm_pkg::SEQ_IDLE;
                    end else if (!stall) begin
                        state <= fm_pkg::SEQ_RUN;
                    end
                end
                default: state <= fm_pkg::SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_sel <= '0;
        end else if (next) begin
            op_sel <= (op_sel == LAST_OP) ? '0 : op_sel + 1'b1;
        end
    end

endmodule

// File: verilog/fm_vib_timer.sv
`timescale 1ns/100ps
`include "fm_config.svh"

module fm_vib_timer #(
    parameter int VIB_DIV = `FM_VIB_DIV
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             sample_tick,
    output fm_pkg::vib_pos_t vib_pos
);

    localparam int CNT_W = (VIB_DIV > 1) ? $clog2(VIB_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(VIB_DIV - 1);

    logic [CNT_W-1:0] sample_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_cnt <= '0;
            vib_pos    <= '0;
        end else if (sample_tick) begin
            if (sample_cnt == CNT_LAST) begin
                sample_cnt <= '0;
                vib_pos    <= vib_pos + 1'b1;   // wraps 7 to 0.
            end else begin
                sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

endmodule

// File: verilog/fm_op_regs.sv
`timescale 1ns/100ps
`include "fm_config.svh"

module fm_op_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               reg_valid,
    output logic               reg_ready,
    input  fm_pkg::op_idx_t    reg_op,
    input  fm_pkg::block_t     reg_block,
    input  fm_pkg::fnum_t      reg_fnum,
    input  fm_pkg::mult_t      reg_mult,
    input  logic               reg_dvb,
    input  logic               reg_vib,
    input  logic               reg_key_on,
    input  fm_pkg::op_idx_t    busy_op,
    input  logic               busy,
    fm_op_params_if.src        params
);

    fm_pkg::block_t block_mem [`FM_NUM_OPS];
    fm_pkg::fnum_t  fnum_mem  [`FM_NUM_OPS];
    fm_pkg::mult_t  mult_mem  [`FM_NUM_OPS];
    logic [`FM_NUM_OPS-1:0] dvb_mem;
    logic [`FM_NUM_OPS-1:0] vib_mem;
    logic [`FM_NUM_OPS-1:0] pending;   // key-on waiting for its slot.

    logic wr_en;

    // the slot being advanced reads its settings this cycle.
    assign reg_ready = !(busy && (reg_op == busy_op));
    assign wr_en     = reg_valid && reg_ready &&
                       (reg_op < fm_pkg::op_idx_t'(`FM_NUM_OPS));

    ////////////////////////////////////////////////////////////
    // read port toward the phase block
    ////////////////////////////////////////////////////////////

    assign params.block   = block_mem[params.op];
    assign params.fnum    = fnum_mem[params.op];
    assign params.mult    = mult_mem[params.op];
    assign params.dvb     = dvb_mem[params.op];
    assign params.vib     = vib_mem[params.op];
    assign params.restart = pending[params.op];

    ////////////////////////////////////////////////////////////
    // host writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FM_NUM_OPS; i++) begin
                block_mem[i] <= '0;
                fnum_mem[i]  <= '0;
                mult_mem[i]  <= '0;
            end
            dvb_mem <= '0;
            vib_mem <= '0;
        end else if (wr_en) begin
            block_mem[reg_op] <= reg_block;
            fnum_mem[reg_op]  <= reg_fnum;
            mult_mem[reg_op]  <= reg_mult;
            dvb_mem[reg_op]   <= reg_dvb;
            vib_mem[reg_op]   <= reg_vib;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            if (params.consume) begin
                pending[params.op] <= 1'b0;   // restart used.
            end
            if (wr_en && reg_key_on) begin
                pending[reg_op] <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/fm_op_data_phase.sv
`timescale 1ns/100ps
`include "fm_config.svh"

module fm_op_data_phase (
    input  logic            clk,
    input  fm_pkg::op_idx_t idx,
    input  logic            wren,
    input  fm_pkg::acc_t    wrdata,
    output fm_pkg::acc_t    rddata
);

    fm_pkg::acc_t mem [`FM_NUM_OPS];

    // read is combinational so the update closes in one cycle.
    assign rddata = mem[idx];

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[idx] <= wrdata;
        end
    end

endmodule

// File: verilog/fm_op_params_if.sv
`timescale 1ns/100ps

interface fm_op_params_if;

    fm_pkg::op_idx_t op;        // read address from the phase block.
    fm_pkg::block_t  block;
    fm_pkg::fnum_t   fnum;
    fm_pkg::mult_t   mult;
    logic            dvb;       // deep vibrato.
    logic            vib;       // vibrato enable.
    logic            restart;   // key-on pending for op.
    logic            consume;   // op accumulated this cycle.

    modport src (
        input  op, consume,
        output block, fnum, mult, dvb, vib, restart
    );

    modport dst (
        output op, consume,
        input  block, fnum, mult, dvb, vib, restart
    );

endinterface

// File: verilog/fm_pkg.sv
`include "fm_config.svh"

package fm_pkg;

    ////////////////////////////////////////////////////////////
    // operator fields
    ////////////////////////////////////////////////////////////

    typedef logic [5:0] op_idx_t;              // operator slot index.
    typedef logic [9:0] fnum_t;                // f-number.
    typedef logic [2:0] block_t;               // octave.
    typedef logic [3:0] mult_t;                // multiplier code.
    typedef logic [2:0] vib_pos_t;             // vibrato position.

    ////////////////////////////////////////////////////////////
    // phase path
    ////////////////////////////////////////////////////////////

    typedef logic [`FM_ACC_W-1:0] acc_t;       // phase accumulator.
    typedef logic [`FM_PHASE_W-1:0] phase_t;   // top accumulator bits.

    // slot sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_RUN   = 2'd1,
        SEQ_STALL = 2'd2
    } seq_state_t;

endpackage

// File: verilog/fm_config.svh
`ifndef FM_CONFIG_SVH
`define FM_CONFIG_SVH

////////////////////////////////////////////////////////////
// operator slots swept once per sample.
////////////////////////////////////////////////////////////

`define FM_NUM_OPS 36

// samples per vibrato position step.
`define FM_VIB_DIV 1024

// per-operator phase accumulator width.
`define FM_ACC_W 19

// accumulator bits that leave as the output phase.
`define FM_PHASE_W 10

`endif
